// ==== filelist.f ====
+incdir+test
design/mem_pkg.sv
design/uart_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/cmd_engine.sv
design/sram_bridge.sv
design/board_top.sv
test/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_top
FILELIST  := filelist.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --timescale 1ns/100ps
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard design/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== test/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

  // ******************************
  // Failure reporting
  // ******************************

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("error: %s: expected 0x%02h actual 0x%02h", name, expected, actual));
    end
  endtask

  task automatic check_word(input string name, input sram_data_t expected,
                            input sram_data_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("error: %s: expected 0x%04h actual 0x%04h", name, expected, actual));
    end
  endtask

  // ******************************
  // Host serial port
  // ******************************

  // Start bit, eight data bits LSB first, stop bit.
  task automatic send_byte(input byte_t data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clock_i);
      uart_rx_i <= frame[i];
      repeat (BIT_CLKS - 1) @(posedge clock_i);
    end
  endtask

  // The line is sampled on falling clock edges, away from its updates.
  task automatic recv_byte(output byte_t data);
    int    waited;
    byte_t value;
    waited = 0;
    value  = '0;
    @(negedge clock_i);
    while (uart_tx_o !== 1'b0) begin
      if (waited == START_TIMEOUT) begin
        abort_run($sformatf("no start bit from the DUT within %0d cycles", START_TIMEOUT));
      end
      waited++;
      @(negedge clock_i);
    end
    repeat (BIT_CLKS / 2) @(negedge clock_i);
    if (uart_tx_o !== 1'b0) begin
      abort_run("start bit from the DUT ended before mid-bit");
    end
    for (int i = 0; i < 8; i++) begin
      repeat (BIT_CLKS) @(negedge clock_i);
      value[i] = uart_tx_o;
    end
    repeat (BIT_CLKS) @(negedge clock_i);
    if (uart_tx_o !== 1'b1) begin
      abort_run("stop bit from the DUT was not high");
    end
    data = value;
  endtask

`endif

// ==== test/tb_top.sv ====
`timescale 1ns/100ps

module tb_top;

  import uart_pkg::*;
  import mem_pkg::*;

  localparam int BIT_CLKS      = 16;
  localparam int MODEL_AW      = 12;
  localparam int START_TIMEOUT = 1000;
  localparam int IDLE_CYCLES   = 200;
  localparam int NUM_BASIC     = 16;
  localparam int NUM_ALIAS     = 8;
  localparam int NUM_MIXED     = 200;

  logic clock_i;
  logic rst_n_i;
  logic uart_rx_i;
  logic uart_tx_o;

  int         seed;
  // Memory model, one word per aliased address.
  sram_data_t model [int];
  int         written [$];

  `include "tb_checks.svh"

  board_top #(
    .CLKS_PER_BIT(BIT_CLKS),
    .MEM_AW      (MODEL_AW)
  ) board_top_i (
    .clock_i   (clock_i),
    .rst_n_i   (rst_n_i),
    .uart_rx_i (uart_rx_i),
    .uart_tx_o (uart_tx_o)
  );

  initial begin
    clock_i = 1'b0;
    forever #5 clock_i = ~clock_i;
  end

  function automatic logic [31:0] next_random();
    return $random(seed);
  endfunction

  function automatic int model_key(input logic [23:0] addr);
    return int'(addr[MODEL_AW-1:0]);
  endfunction

  // A written word, reached with random upper address bits.
  function automatic logic [23:0] written_addr();
    logic [31:0] r;
    logic [31:0] k;
    r = next_random();
    k = written[r % written.size()];
    r = next_random();
    return {r[23:MODEL_AW], k[MODEL_AW-1:0]};
  endfunction

  // ******************************
  // Host commands
  // ******************************

  task automatic write_cmd(input byte_t cmd, input logic [23:0] addr, input sram_data_t data,
                           input string name);
    byte_t      rsp;
    sram_data_t old;
    int         key;
    key = model_key(addr);
    send_byte(cmd);
    send_byte(addr[23:16]);
    send_byte(addr[15:8]);
    send_byte(addr[7:0]);
    send_byte(data[15:8]);
    fork
      send_byte(data[7:0]);
      recv_byte(rsp);
    join
    check_byte(name, RSP_ACK, rsp);
    if (!model.exists(key)) begin
      written.push_back(key);
    end
    old = model.exists(key) ? model[key] : data;
    case (cmd)
      CMD_WRITE_LOW:  model[key] = {old[15:8], data[7:0]};
      CMD_WRITE_HIGH: model[key] = {data[15:8], old[7:0]};
      default:        model[key] = data;
    endcase
  endtask

  // Upper byte comes back first.
  task automatic read_cmd(input logic [23:0] addr, input string name);
    byte_t hi;
    byte_t lo;
    send_byte(CMD_READ);
    send_byte(addr[23:16]);
    send_byte(addr[15:8]);
    fork
      send_byte(addr[7:0]);
      begin
        recv_byte(hi);
        recv_byte(lo);
      end
    join
    check_word(name, model[model_key(addr)], {hi, lo});
  endtask

  task automatic lane_write(input string name);
    logic [31:0] r;
    byte_t       cmd;
    r   = next_random();
    cmd = r[0] ? CMD_WRITE_LOW : CMD_WRITE_HIGH;
    write_cmd(cmd, written_addr(), r[31:16], name);
  endtask

  task automatic bad_cmd(input string name);
    byte_t cmd;
    byte_t rsp;
    cmd = CMD_READ;
    while (cmd inside {CMD_WRITE_WORD, CMD_WRITE_LOW, CMD_WRITE_HIGH, CMD_READ}) begin
      cmd = byte_t'(next_random());
    end
    fork
      send_byte(cmd);
      recv_byte(rsp);
    join
    check_byte(name, RSP_ERR, rsp);
  endtask

  // ******************************
  // Test sequence
  // ******************************

  initial begin
    logic [23:0] addr;
    logic [31:0] r;
    int          pick;
    seed = 32'h31dde19c;
    rst_n_i   <= 1'b0;
    uart_rx_i <= 1'b1;
    repeat (16) @(posedge clock_i);
    rst_n_i <= 1'b1;

    // Nothing is sent without a command.
    for (int i = 0; i < IDLE_CYCLES; i++) begin
      @(negedge clock_i);
      if (uart_tx_o !== 1'b1) begin
        abort_run("transmit line left the idle level after reset");
      end
    end

    for (int i = 0; i < NUM_BASIC; i++) begin
      r = next_random();
      write_cmd(CMD_WRITE_WORD, r[23:0], sram_data_t'(next_random()), "word write");
    end
    foreach (written[i]) begin
      read_cmd(24'(written[i]), "word read");
    end

    for (int i = 0; i < NUM_BASIC; i++) begin
      lane_write("lane write");
    end
    foreach (written[i]) begin
      read_cmd(24'(written[i]), "lane read");
    end

    // Bit 12 always flips, so the alias differs inside the 18-bit bus.
    for (int i = 0; i < NUM_ALIAS; i++) begin
      r    = next_random();
      addr = r[23:0];
      write_cmd(CMD_WRITE_WORD, addr, sram_data_t'(next_random()), "alias write");
      addr[23:MODEL_AW] = addr[23:MODEL_AW] ^ (r[31:20] | 12'h001);
      read_cmd(addr, "alias read");
    end

    for (int i = 0; i < NUM_ALIAS; i++) begin
      bad_cmd("unknown command");
      read_cmd(written_addr(), "read after unknown command");
    end

    // Mostly reads of written words.
    for (int i = 0; i < NUM_MIXED; i++) begin
      r    = next_random();
      pick = int'(r % 100);
      if (pick < 50) begin
        read_cmd(written_addr(), "mixed read");
      end else if (pick < 75) begin
        r = next_random();
        write_cmd(CMD_WRITE_WORD, r[23:0], r[31:16], "mixed word write");
      end else if (pick < 90) begin
        lane_write("mixed lane write");
      end else begin
        bad_cmd("mixed unknown command");
      end
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== design/board_top.sv ====
`timescale 1ns/100ps

module board_top #(
  parameter int CLKS_PER_BIT = 16,
  parameter int MEM_AW       = 12
) (
  input  logic clock_i,
  input  logic rst_n_i,
  input  logic uart_rx_i,
  output logic uart_tx_o
);

  import uart_pkg::*;
  import mem_pkg::*;

  logic       rx_valid;
  byte_t      rx_data;
  logic       tx_start;
  byte_t      tx_data;
  logic       tx_busy;

  logic       sram_ce_n;
  logic       sram_we_n;
  logic       sram_oe_n;
  logic       sram_ub_n;
  logic       sram_lb_n;
  sram_addr_t sram_addr;
  sram_data_t sram_wdata;
  sram_data_t sram_rdata;

  // ******************************
  // Host serial port
  // ******************************

  uart_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) uart_rx_i0 (
    .clock_i    (clock_i),
    .rst_n_i    (rst_n_i),
    .rx_i       (uart_rx_i),
    .rx_valid_o (rx_valid),
    .rx_data_o  (rx_data)
  );

  uart_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) uart_tx_i0 (
    .clock_i    (clock_i),
    .rst_n_i    (rst_n_i),
    .tx_start_i (tx_start),
    .tx_data_i  (tx_data),
    .tx_o       (uart_tx_o),
    .tx_busy_o  (tx_busy)
  );

  // ******************************
  // Engine and memory
  // ******************************

  cmd_engine cmd_engine_i0 (
    .clock_i     (clock_i),
    .rst_n_i     (rst_n_i),
    .rx_valid_i  (rx_valid),
    .rx_data_i   (rx_data),
    .tx_busy_i   (tx_busy),
    .sram_dq_i   (sram_rdata),
    .tx_start_o  (tx_start),
    .tx_data_o   (tx_data),
    .sram_ce_n_o (sram_ce_n),
    .sram_we_n_o (sram_we_n),
    .sram_oe_n_o (sram_oe_n),
    .sram_ub_n_o (sram_ub_n),
    .sram_lb_n_o (sram_lb_n),
    .sram_addr_o (sram_addr),
    .sram_dq_o   (sram_wdata)
  );

  sram_bridge #(
    .MEM_AW(MEM_AW)
  ) sram_bridge_i0 (
    .clock_i     (clock_i),
    .sram_ce_n_i (sram_ce_n),
    .sram_we_n_i (sram_we_n),
    .sram_oe_n_i (sram_oe_n),
    .sram_ub_n_i (sram_ub_n),
    .sram_lb_n_i (sram_lb_n),
    .sram_addr_i (sram_addr),
    .sram_dq_i   (sram_wdata),
    .sram_dq_o   (sram_rdata)
  );

endmodule

// ==== design/sram_bridge.sv ====
`timescale 1ns/100ps

module sram_bridge #(
  parameter int MEM_AW = 12
) (
  input  logic                clock_i,
  input  logic                sram_ce_n_i,
  input  logic                sram_we_n_i,
  input  logic                sram_oe_n_i,
  input  logic                sram_ub_n_i,
  input  logic                sram_lb_n_i,
  input  mem_pkg::sram_addr_t sram_addr_i,
  input  mem_pkg::sram_data_t sram_dq_i,
  output mem_pkg::sram_data_t sram_dq_o
);

  import mem_pkg::*;

  localparam int LANE_W = SRAM_DW / 2;

  sram_data_t        mem_q [2**MEM_AW];
  sram_data_t        dq_q;
  logic [MEM_AW-1:0] index;
  logic              wr_en;
  logic              rd_en;

  // Upper address bits are ignored, so the array aliases.
  assign index = sram_addr_i[MEM_AW-1:0];
  assign wr_en = !sram_ce_n_i && !sram_we_n_i;
  assign rd_en = !sram_ce_n_i && !sram_oe_n_i;

  // Each byte lane has its own write strobe.
  always_ff @(posedge clock_i) begin
    if (wr_en && !sram_ub_n_i) begin
      mem_q[index][SRAM_DW-1:LANE_W] <= sram_dq_i[SRAM_DW-1:LANE_W];
    end
    if (wr_en && !sram_lb_n_i) begin
      mem_q[index][LANE_W-1:0] <= sram_dq_i[LANE_W-1:0];
    end
  end

  // Read word is ready on the second cycle of the read.
  always_ff @(posedge clock_i) begin
    if (rd_en) begin
      dq_q <= mem_q[index];
    end
  end

  assign sram_dq_o = dq_q;

endmodule

// ==== design/cmd_engine.sv ====
`timescale 1ns/100ps

module cmd_engine (
  input  logic                clock_i,
  input  logic                rst_n_i,
  input  logic                rx_valid_i,
  input  uart_pkg::byte_t     rx_data_i,
  input  logic                tx_busy_i,
  input  mem_pkg::sram_data_t sram_dq_i,
  output logic                tx_start_o,
  output uart_pkg::byte_t     tx_data_o,
  output logic                sram_ce_n_o,
  output logic                sram_we_n_o,
  output logic                sram_oe_n_o,
  output logic                sram_ub_n_o,
  output logic                sram_lb_n_o,
  output mem_pkg::sram_addr_t sram_addr_o,
  output mem_pkg::sram_data_t sram_dq_o
);

  import uart_pkg::*;
  import mem_pkg::*;

  typedef enum logic [2:0] {
    S_CMD, S_ADDR, S_DATA, S_WRITE, S_READ1, S_READ2, S_RESP
  } state_t;

  state_t     state_q;
  logic [1:0] cnt_q;
  logic [1:0] rsp_cnt_q;
  byte_t      cmd_q;
  sram_addr_t addr_q;
  sram_data_t data_q;
  sram_data_t rsp_q;
  logic       cmd_known;
  logic       is_read;
  logic       tx_send;
  logic       bus_active;

  assign cmd_known = rx_data_i inside {CMD_WRITE_WORD, CMD_WRITE_LOW, CMD_WRITE_HIGH, CMD_READ};
  assign is_read   = (cmd_q == CMD_READ);

  // Start waits one cycle after a pulse because busy rises late.
  assign tx_send = (state_q == S_RESP) && !tx_busy_i && !tx_start_o && (rsp_cnt_q != 2'd0);

  // ******************************
  // Command FSM
  // ******************************

  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      state_q    <= S_CMD;
      cnt_q      <= '0;
      rsp_cnt_q  <= '0;
      tx_start_o <= 1'b0;
    end else begin
      tx_start_o <= tx_send;
      case (state_q)
        S_CMD: begin
          cnt_q <= '0;
          if (rx_valid_i) begin
            if (cmd_known) begin
              state_q <= S_ADDR;
            end else begin
              rsp_cnt_q <= 2'd1;
              state_q   <= S_RESP;
            end
          end
        end
        S_ADDR: begin
          if (rx_valid_i) begin
            cnt_q <= (cnt_q == 2'd2) ? 2'd0 : cnt_q + 1'b1;
            if (cnt_q == 2'd2) begin
              state_q <= is_read ? S_READ1 : S_DATA;
            end
          end
        end
        S_DATA: begin
          if (rx_valid_i) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == 2'd1) begin
              state_q <= S_WRITE;
            end
          end
        end
        S_WRITE: begin
          rsp_cnt_q <= 2'd1;
          state_q   <= S_RESP;
        end
        S_READ1: state_q <= S_READ2;
        S_READ2: begin
          rsp_cnt_q <= 2'd2;
          state_q   <= S_RESP;
        end
        default: begin
          if (tx_send) begin
            rsp_cnt_q <= rsp_cnt_q - 1'b1;
          end else if (rsp_cnt_q == 2'd0 && !tx_busy_i && !tx_start_o) begin
            state_q <= S_CMD;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock_i) begin
    if (state_q == S_CMD && rx_valid_i) begin
      cmd_q <= rx_data_i;
      rsp_q <= {RSP_ERR, 8'h00};
    end
    if (state_q == S_ADDR && rx_valid_i) begin
      addr_q <= {addr_q[SRAM_AW-9:0], rx_data_i};
    end
    if (state_q == S_DATA && rx_valid_i) begin
      data_q <= {data_q[SRAM_DW-9:0], rx_data_i};
    end
    if (state_q == S_WRITE) begin
      rsp_q <= {RSP_ACK, 8'h00};
    end
    // Read data is sampled on the second bus cycle.
    if (state_q == S_READ2) begin
      rsp_q <= sram_dq_i;
    end
    if (tx_send) begin
      tx_data_o <= rsp_q[SRAM_DW-1:SRAM_DW-8];
      rsp_q     <= {rsp_q[SRAM_DW-9:0], 8'h00};
    end
  end

  // ******************************
  // SRAM bus
  // ******************************

  assign bus_active  = (state_q == S_WRITE) || (state_q == S_READ1) || (state_q == S_READ2);
  assign sram_ce_n_o = !bus_active;
  assign sram_we_n_o = (state_q != S_WRITE);
  assign sram_oe_n_o = !((state_q == S_READ1) || (state_q == S_READ2));
  assign sram_ub_n_o = !bus_active || (cmd_q == CMD_WRITE_LOW);
  assign sram_lb_n_o = !bus_active || (cmd_q == CMD_WRITE_HIGH);
  assign sram_addr_o = addr_q;
  assign sram_dq_o   = data_q;

endmodule

// ==== design/uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic            clock_i,
  input  logic            rst_n_i,
  input  logic            tx_start_i,
  input  uart_pkg::byte_t tx_data_i,
  output logic            tx_o,
  output logic            tx_busy_o
);

  import uart_pkg::*;

  localparam int CW = $clog2(CLKS_PER_BIT);
  localparam logic [CW-1:0] FULL_BIT = CW'(CLKS_PER_BIT - 1);

  logic [CW-1:0] div_q;
  logic [3:0]    bit_q;
  logic [8:0]    shift_q;
  logic          load;
  logic          bit_end;

  assign load    = tx_start_i && !tx_busy_o;
  assign bit_end = tx_busy_o && (div_q == FULL_BIT);

  // Bit 0 is the start bit, 9 the stop bit.
  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      tx_o      <= 1'b1;
      tx_busy_o <= 1'b0;
      div_q     <= '0;
      bit_q     <= '0;
    end else if (load) begin
      tx_o      <= 1'b0;
      tx_busy_o <= 1'b1;
      div_q     <= '0;
      bit_q     <= '0;
    end else if (tx_busy_o) begin
      div_q <= bit_end ? '0 : div_q + 1'b1;
      if (bit_end) begin
        bit_q <= bit_q + 1'b1;
        if (bit_q == 4'd9) begin
          tx_busy_o <= 1'b0;
        end else begin
          tx_o <= shift_q[0];
        end
      end
    end
  end

  // Data bits with the stop bit above them.
  always_ff @(posedge clock_i) begin
    if (load) begin
      shift_q <= {1'b1, tx_data_i};
    end else if (bit_end) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

endmodule

// ==== design/uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic            clock_i,
  input  logic            rst_n_i,
  input  logic            rx_i,
  output logic            rx_valid_o,
  output uart_pkg::byte_t rx_data_o
);

  import uart_pkg::*;

  localparam int CW = $clog2(CLKS_PER_BIT);
  localparam logic [CW-1:0] HALF_BIT = CW'(CLKS_PER_BIT / 2 - 1);
  localparam logic [CW-1:0] FULL_BIT = CW'(CLKS_PER_BIT - 1);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t     state_q;
  logic          rx_meta_q;
  logic          rx_sync_q;
  logic [CW-1:0] div_q;
  logic [2:0]    bit_q;
  byte_t         shift_q;
  logic          sample;

  // Data bits are taken one full bit after the mid-bit start check.
  assign sample = (state_q == RX_DATA) && (div_q == FULL_BIT);

  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      rx_meta_q  <= 1'b1;
      rx_sync_q  <= 1'b1;
      state_q    <= RX_IDLE;
      div_q      <= '0;
      bit_q      <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_meta_q  <= rx_i;
      rx_sync_q  <= rx_meta_q;
      rx_valid_o <= 1'b0;
      div_q      <= div_q + 1'b1;
      case (state_q)
        RX_IDLE: begin
          div_q <= '0;
          if (!rx_sync_q) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          if (div_q == HALF_BIT) begin
            // A short low pulse is a glitch, not a start bit.
            div_q   <= '0;
            bit_q   <= '0;
            state_q <= rx_sync_q ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (sample) begin
            div_q <= '0;
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end
        end
        default: begin
          if (div_q == FULL_BIT) begin
            state_q    <= RX_IDLE;
            rx_valid_o <= rx_sync_q;
          end
        end
      endcase
    end
  end

  // LSB first, so new bits enter at the top.
  always_ff @(posedge clock_i) begin
    if (sample) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign rx_data_o = shift_q;

endmodule

// ==== design/uart_pkg.sv ====
package uart_pkg;

  // ******************************
  // Host serial protocol
  // ******************************

  // One UART payload byte.
  typedef logic [7:0] byte_t;

  // Command bytes sent by the host.
  localparam byte_t CMD_WRITE_WORD = 8'h57;
  localparam byte_t CMD_WRITE_LOW  = 8'h4C;
  localparam byte_t CMD_WRITE_HIGH = 8'h55;
  localparam byte_t CMD_READ       = 8'h52;

  // Response bytes sent back to the host.
  localparam byte_t RSP_ACK = 8'h4B;
  localparam byte_t RSP_ERR = 8'h3F;

endpackage

// ==== design/mem_pkg.sv ====
package mem_pkg;

  // ******************************
  // Asynchronous SRAM bus geometry
  // ******************************

  // Word address width of the bus.
  localparam int SRAM_AW = 18;

  // Data width of the bus, two byte lanes.
  localparam int SRAM_DW = 16;

  // Word address on the bus.
  typedef logic [SRAM_AW-1:0] sram_addr_t;

  // Data word on the bus, upper lane in the top byte.
  typedef logic [SRAM_DW-1:0] sram_data_t;

endpackage
